// ==== build.f ====
cpuTypesPkg.sv
exMemLatch.sv
dataMemory.sv
memWbLatch.sv
writebackRegs.sv
memBackEnd.sv
memBackEnd_chk.sv
memBackEnd_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run memBackEnd_tb with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module memBackEnd_tb -f build.f -o simv
if [ $? -ne 0 ]; then
        echo "verilator compile failed"
        exit 1
fi

# keep running past assertion errors so the testbench can report them
output=$(./obj_dir/simv +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
        exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== memBackEnd_tb.sv ====
`default_nettype none

module memBackEnd_tb
        import cpuTypesPkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        logic     CLK;
        logic     nRST;
        logic     ihit;
        logic     flush;
        exMem_t   exIn;
        regAddr_t rdAddr;
        word_t    rdData;
        logic     halt;
        logic     busy;

        int    errors;
        word_t regModel [32];
        word_t memModel [256];

        memBackEnd #(
                .MemWords   (256),
                .MemLatency (3)
        ) memBackEnd_i (
                .CLK    (CLK),
                .nRST   (nRST),
                .ihit   (ihit),
                .flush  (flush),
                .exIn   (exIn),
                .rdAddr (rdAddr),
                .rdData (rdData),
                .halt   (halt),
                .busy   (busy)
        );

        initial begin
                CLK = 1'b0;
                forever #5 CLK = ~CLK;
        end

        function automatic exMem_t aluOp(regAddr_t rd, regAddr_t rt, logic regDst, word_t v);
                exMem_t ins;
                ins = '0;
                ins.RegWr = 1'b1;
                ins.RegDst = regDst;
                ins.Rd = rd;
                ins.Rt = rt;
                ins.portO = v;
                ins.NPC = $urandom;
                return ins;
        endfunction

        // write selects store, otherwise a load into rt
        function automatic exMem_t memOp(logic write, word_t addr, word_t data, regAddr_t rt);
                exMem_t ins;
                ins = '0;
                ins.dWEN = write;
                ins.dREN = !write;
                ins.RegWr = !write;
                ins.MemtoReg = !write;
                ins.Rd = regAddr_t'($urandom);
                ins.Rt = rt;
                ins.portO = addr;
                ins.dmemstore = data;
                return ins;
        endfunction

        function automatic exMem_t jalOp(word_t npc);
                exMem_t ins;
                ins = '0;
                ins.jal = 1'b1;
                ins.RegWr = 1'b1;
                ins.RegDst = 1'b1;
                ins.Rd = regAddr_t'($urandom);
                ins.Rt = regAddr_t'($urandom);
                ins.NPC = npc;
                ins.portO = $urandom;
                return ins;
        endfunction

        function automatic exMem_t luiOp(imm16_t imm, regAddr_t rd);
                exMem_t ins;
                ins = '0;
                ins.luiSel = 1'b1;
                ins.RegWr = 1'b1;
                ins.RegDst = 1'b1;
                ins.Rd = rd;
                ins.LUI = imm;
                ins.portO = $urandom;
                return ins;
        endfunction

        task automatic expectBit(input logic got, input logic want, input string what);
                assert (got === want) else begin
                        errors++;
                        $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
                end
        endtask

        // one idle edge, then hold off until the memory is free
        task automatic waitIdle();
                int n;
                n = 0;
                @(posedge CLK);
                #1;
                while (busy && n < 20) begin
                        @(posedge CLK);
                        #1;
                        n++;
                end
                if (busy) begin
                        errors++;
                        $display("timeout at %0t: data memory stayed busy", $time);
                        $display("TB FAILED");
                        $finish;
                end
        endtask

        task automatic issue(input exMem_t ins);
                waitIdle();
                exIn = ins;
                ihit = 1'b1;
                @(posedge CLK);
                #1;
                ihit = 1'b0;
                exIn = '0;
        endtask

        task automatic drain();
                issue('0);
                issue('0);
        endtask

        task automatic checkAll();
                for (int r = 0; r < 32; r++) begin
                        @(posedge CLK);
                        #1;
                        rdAddr = regAddr_t'(r);
                        #3;
                        assert (rdData === regModel[r]) else begin
                                errors++;
                                $display("mismatch at %0t: r%0d reads %h, expected %h",
                                         $time, r, rdData, regModel[r]);
                        end
                end
        endtask

        task automatic writeModel(input regAddr_t dest, input word_t v);
                if (dest != '0) begin
                        regModel[dest] = v;
                end
        endtask

        initial begin
                regAddr_t rd;
                regAddr_t rt;
                logic     sel;
                word_t    v;
                word_t    addr;
                int       idx;
                imm16_t   imm;

                errors = 0;
                nRST = 1'b0;
                ihit = 1'b0;
                flush = 1'b0;
                exIn = '0;
                rdAddr = '0;
                for (int i = 0; i < 32; i++) begin
                        regModel[i] = '0;
                end
                for (int i = 0; i < 256; i++) begin
                        memModel[i] = '0;
                end
                void'($urandom(32'h65e86059));
                repeat (2) @(posedge CLK);
                #1;
                nRST = 1'b1;
                expectBit(busy, 1'b0, "busy after reset");
                expectBit(halt, 1'b0, "halt after reset");

                // ALU results into Rd or Rt
                for (int k = 0; k < 8; k++) begin
                        rd = regAddr_t'($urandom);
                        rt = regAddr_t'($urandom);
                        sel = 1'($urandom);
                        v = $urandom;
                        issue(aluOp(rd, rt, sel, v));
                        writeModel(sel ? rd : rt, v);
                        drain();
                        checkAll();
                end

                // store then load back, plus one load from anywhere
                for (int k = 0; k < 5; k++) begin
                        addr = $urandom & 32'hFFFF_FFFC;
                        idx = int'((addr >> 2) % 256);
                        v = $urandom;
                        if (k < 4) begin
                                issue(memOp(1'b1, addr, v, '0));
                                expectBit(busy, 1'b1, "busy after a store");
                                memModel[idx] = v;
                        end
                        rt = regAddr_t'(($urandom % 31) + 1);
                        issue(memOp(1'b0, addr, '0, rt));
                        expectBit(busy, 1'b1, "busy after a load");
                        writeModel(rt, memModel[idx]);
                        drain();
                        checkAll();
                end

                // link register and upper immediate
                v = $urandom;
                issue(jalOp(v));
                writeModel(linkReg, v);
                imm = imm16_t'($urandom);
                rd = regAddr_t'(($urandom % 30) + 1);
                issue(luiOp(imm, rd));
                writeModel(rd, {imm, 16'h0000});
                drain();
                checkAll();

                // flushed before the next ihit, so nothing lands
                for (int k = 0; k < 2; k++) begin
                        rd = regAddr_t'(($urandom % 31) + 1);
                        v = ~regModel[rd];
                        issue(aluOp(rd, '0, 1'b1, v));
                        flush = 1'b1;
                        @(posedge CLK);
                        #1;
                        flush = 1'b0;
                        drain();
                        checkAll();
                end

                // r0 is not writable through any path
                issue(aluOp('0, 5'd3, 1'b1, $urandom));
                issue(luiOp(imm16_t'($urandom), '0));
                issue(memOp(1'b0, addr, '0, '0));
                drain();
                checkAll();

                // halt is sticky across later instructions
                expectBit(halt, 1'b0, "halt before a halt instruction");
                exIn = '0;
                issue('{halt: 1'b1, default: '0});
                drain();
                expectBit(halt, 1'b1, "halt after a halt instruction");
                for (int k = 0; k < 3; k++) begin
                        rt = regAddr_t'($urandom);
                        v = $urandom;
                        issue(aluOp('0, rt, 1'b0, v));
                        writeModel(rt, v);
                end
                drain();
                expectBit(halt, 1'b1, "halt after later instructions");
                checkAll();

                $display("errors: %0d testbench checks, %0d assertion failures",
                         errors, memBackEnd_i.chk_i.failCount);
                if (errors == 0 && memBackEnd_i.chk_i.failCount == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== memBackEnd_chk.sv ====
`default_nettype none

module memBackEnd_chk
#(
        parameter int MemLatency = 3
)
(
        input  logic CLK,
        input  logic nRST,
        input  logic dhit,
        input  logic busy
);

        timeunit 1ns;
        timeprecision 1ps;

        int unsigned failCount = 0;
        int          busyLen;

        // consecutive sampled busy cycles
        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        busyLen <= 0;
                end else if (busy) begin
                        busyLen <= busyLen + 1;
                end else begin
                        busyLen <= 0;
                end
        end

        // the access completes a fixed latency after it starts
        dhitAfterLatency: assert property (@(posedge CLK) disable iff (!nRST)
                        $rose(busy) |-> ##MemLatency dhit)
                else begin
                        failCount++;
                        $error("dhit did not arrive at the access latency after busy rose");
                end

        // busy lasts from the request through the dhit cycle only
        busyBounded: assert property (@(posedge CLK) disable iff (!nRST)
                        busy |-> busyLen <= MemLatency)
                else begin
                        failCount++;
                        $error("busy stayed high longer than the access latency allows");
                end

        // cleared EX/MEM latch lets the memory go idle
        idleAfterDhit: assert property (@(posedge CLK) disable iff (!nRST) dhit |=> !busy)
                else begin
                        failCount++;
                        $error("data memory restarted right after dhit");
                end

endmodule

bind memBackEnd memBackEnd_chk #(.MemLatency(MemLatency)) chk_i (
        .CLK  (CLK),
        .nRST (nRST),
        .dhit (dhit),
        .busy (busy)
);

`default_nettype wire

// ==== memBackEnd.sv ====
`default_nettype none

module memBackEnd
        import cpuTypesPkg::*;
#(
        parameter int MemWords   = 256,
        parameter int MemLatency = 3
)
(
        input  logic     CLK,
        input  logic     nRST,
        input  logic     ihit,
        input  logic     flush,
        input  exMem_t   exIn,
        input  regAddr_t rdAddr,
        output word_t    rdData,
        output logic     halt,
        output logic     busy
);

        exMem_t emOut;
        memWb_t wbOut;
        logic   dhit;
        word_t  loadData;

        exMemLatch exMemLatch_i (
                .CLK   (CLK),
                .nRST  (nRST),
                .ihit  (ihit),
                .flush (flush),
                .dhit  (dhit),
                .exIn  (exIn),
                .emOut (emOut)
        );

        dataMemory #(
                .MemWords   (MemWords),
                .MemLatency (MemLatency)
        ) dataMemory_i (
                .CLK      (CLK),
                .nRST     (nRST),
                .emOut    (emOut),
                .dhit     (dhit),
                .loadData (loadData),
                .busy     (busy)
        );

        memWbLatch memWbLatch_i (
                .CLK      (CLK),
                .nRST     (nRST),
                .ihit     (ihit),
                .dhit     (dhit),
                .emOut    (emOut),
                .loadData (loadData),
                .wbOut    (wbOut)
        );

        writebackRegs writebackRegs_i (
                .CLK    (CLK),
                .nRST   (nRST),
                .wbOut  (wbOut),
                .rdAddr (rdAddr),
                .rdData (rdData),
                .halt   (halt)
        );

endmodule

`default_nettype wire

// ==== writebackRegs.sv ====
`default_nettype none

module writebackRegs
        import cpuTypesPkg::*;
(
        input  logic     CLK,
        input  logic     nRST,
        input  memWb_t   wbOut,
        input  regAddr_t rdAddr,
        output word_t    rdData,
        output logic     halt
);

        regAddr_t dest;
        word_t    value;

        // r0 has no storage
        word_t regs [1:31];

        // destination priority jal, then Rd, then Rt
        always_comb begin
                if (wbOut.jal) begin
                        dest = linkReg;
                end else if (wbOut.RegDst) begin
                        dest = wbOut.Rd;
                end else begin
                        dest = wbOut.Rt;
                end
        end

        always_comb begin
                if (wbOut.jal) begin
                        value = wbOut.NPC;
                end else if (wbOut.luiSel) begin
                        value = {wbOut.LUI, 16'h0000};
                end else if (wbOut.MemtoReg) begin
                        value = wbOut.loadData;
                end else begin
                        value = wbOut.portO;
                end
        end

        // held instructions rewrite the same value each cycle
        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wbOut.RegWr && (dest != '0)) begin
                        regs[dest] <= value;
                end
        end

        assign rdData = (rdAddr == '0) ? '0 : regs[rdAddr];

        // sticky until reset
        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        halt <= 1'b0;
                end else if (wbOut.halt) begin
                        halt <= 1'b1;
                end
        end

endmodule

`default_nettype wire

// ==== memWbLatch.sv ====
`default_nettype none

module memWbLatch
        import cpuTypesPkg::*;
(
        input  logic   CLK,
        input  logic   nRST,
        input  logic   ihit,
        input  logic   dhit,
        input  exMem_t emOut,
        input  word_t  loadData,
        output memWb_t wbOut
);

        logic   memOp;
        logic   load;
        memWb_t next;

        assign memOp = emOut.dREN | emOut.dWEN;

        // memory ops wait for dhit, everything else moves on ihit
        assign load = dhit || (ihit && !memOp);

        // memory controls are not needed past this point
        assign next = '{
                jal:      emOut.jal,
                RegDst:   emOut.RegDst,
                RegWr:    emOut.RegWr,
                MemtoReg: emOut.MemtoReg,
                halt:     emOut.halt,
                luiSel:   emOut.luiSel,
                NPC:      emOut.NPC,
                Rd:       emOut.Rd,
                Rt:       emOut.Rt,
                portO:    emOut.portO,
                LUI:      emOut.LUI,
                loadData: loadData
        };

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        wbOut <= '0;
                end else if (load) begin
                        wbOut <= next;
                end
        end

endmodule

`default_nettype wire

// ==== dataMemory.sv ====
`default_nettype none

module dataMemory
        import cpuTypesPkg::*;
#(
        parameter int MemWords   = 256,
        parameter int MemLatency = 3
)
(
        input  logic   CLK,
        input  logic   nRST,
        input  exMem_t emOut,
        output logic   dhit,
        output word_t  loadData,
        output logic   busy
);

        localparam int IdxW = (MemWords > 1) ? $clog2(MemWords) : 1;
        localparam int CntW = $clog2(MemLatency + 1);

        memState_e       state;
        logic [CntW-1:0] cnt;
        logic            request;
        logic            start;
        word_t           wordAddr;
        logic [IdxW-1:0] idx;

        word_t mem [MemWords] = '{default: '0};

        // byte address to word index, wrapping at the memory depth
        assign wordAddr = emOut.portO >> 2;
        assign idx      = IdxW'(wordAddr % MemWords);

        assign request = emOut.dREN | emOut.dWEN;
        assign start   = (state == memIdle) && request;

        // data is valid on the last wait cycle only
        assign dhit     = (state == memWait) && (cnt == '0);
        assign busy     = start || (state == memWait);
        assign loadData = mem[idx];

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        state <= memIdle;
                        cnt   <= '0;
                end else begin
                        case (state)
                                memIdle: begin
                                        if (request) begin
                                                state <= memWait;
                                                cnt   <= CntW'(MemLatency - 1);
                                        end
                                end
                                memWait: begin
                                        if (cnt == '0) begin
                                                // latch clears on dhit, so idle sees a bubble next
                                                state <= memIdle;
                                        end else begin
                                                cnt <= cnt - CntW'(1);
                                        end
                                end
                                default: begin
                                        state <= memIdle;
                                end
                        endcase
                end
        end

        // store commits on the dhit cycle
        always_ff @(posedge CLK) begin
                if (dhit && emOut.dWEN) begin
                        mem[idx] <= emOut.dmemstore;
                end
        end

endmodule

`default_nettype wire

// ==== exMemLatch.sv ====
`default_nettype none

module exMemLatch
        import cpuTypesPkg::*;
(
        input  logic   CLK,
        input  logic   nRST,
        input  logic   ihit,
        input  logic   flush,
        input  logic   dhit,
        input  exMem_t exIn,
        output exMem_t emOut
);

        // bubble is all zeros, so no memory op and no register write
        localparam exMem_t bubble = '0;

        always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                        emOut <= bubble;
                end else if (flush || dhit) begin
                        // a finished access leaves a bubble behind
                        emOut <= bubble;
                end else if (ihit) begin
                        emOut <= exIn;
                end
        end

endmodule

`default_nettype wire

// ==== cpuTypesPkg.sv ====
`default_nettype none

package cpuTypesPkg;

        // basic widths
        typedef logic [31:0] word_t;
        typedef logic [4:0]  regAddr_t;
        typedef logic [15:0] imm16_t;

        // jal always links through r31
        localparam regAddr_t linkReg = 5'd31;

        // data memory sequencer
        typedef enum logic {
                memIdle,
                memWait
        } memState_e;

        // everything held between execute and memory
        typedef struct packed {
                // memory controls
                logic     dREN;
                logic     dWEN;
                // writeback controls
                logic     jal;
                logic     RegDst;
                logic     RegWr;
                logic     MemtoReg;
                logic     halt;
                logic     luiSel;
                // data
                word_t    NPC;
                regAddr_t Rd;
                regAddr_t Rt;
                word_t    portO;
                imm16_t   LUI;
                word_t    dmemstore;
        } exMem_t;

        // everything held between memory and writeback
        typedef struct packed {
                // writeback controls
                logic     jal;
                logic     RegDst;
                logic     RegWr;
                logic     MemtoReg;
                logic     halt;
                logic     luiSel;
                // data
                word_t    NPC;
                regAddr_t Rd;
                regAddr_t Rt;
                word_t    portO;
                imm16_t   LUI;
                word_t    loadData;
        } memWb_t;

endpackage

`default_nettype wire
